//--- design/mem_pkg.sv
package mem_pkg;

    localparam int ADDR_W      = 32;
    localparam int DATA_W      = 32;
    localparam int BYTES       = DATA_W / 8;
    localparam int MEM_WORDS   = 256;
    localparam int MEM_IDX_W   = $clog2(MEM_WORDS);
    localparam int MEM_LATENCY = 4;
    localparam int LAT_W       = $clog2(MEM_LATENCY + 1);
    localparam int CACHE_LINES = 16;
    localparam int OFFSET_W    = 2;
    localparam int IDX_W       = $clog2(CACHE_LINES);
    localparam int TAG_W       = ADDR_W - IDX_W - OFFSET_W;

    typedef struct packed {
        logic              req;
        logic [ADDR_W-1:0] addr;
        logic              kill;
    } fetch_req_t;

    typedef struct packed {
        logic              ack;
        logic [DATA_W-1:0] data;
    } fetch_rsp_t;

    // Also the upstream port of the data cache
    typedef struct packed {
        logic              req;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] w_data;
        logic [BYTES-1:0]  sel_byte;
        logic              w_en;
    } lsu_req_t;

    typedef struct packed {
        logic              ack;
        logic [DATA_W-1:0] r_data;
    } lsu_rsp_t;

    typedef struct packed {
        logic              r_req;
        logic [ADDR_W-1:0] paddr;
        logic              flush_req;
    } mmu_req_t;

    typedef struct packed {
        logic              r_valid;
        logic [DATA_W-1:0] r_data;
    } mmu_rsp_t;

    typedef lsu_req_t mem_req_t;

    typedef struct packed {
        logic              ack;
        logic [DATA_W-1:0] r_data;
    } mem_rsp_t;

    typedef enum logic [1:0] {PORT_IDLE, PORT_LSU, PORT_MMU} port_arb_state_e;

    typedef enum logic [2:0] {
        MEM_IDLE, MEM_DCACHE, MEM_ICACHE, MEM_DKILL, MEM_IKILL
    } mem_arb_state_e;

    typedef enum logic [1:0] {CACHE_IDLE, CACHE_MISS, CACHE_WRITE} cache_state_e;

    // Replace the enabled bytes of a word
    function automatic logic [DATA_W-1:0] merge_bytes(
        input logic [DATA_W-1:0] old_word,
        input logic [DATA_W-1:0] new_word,
        input logic [BYTES-1:0]  sel
    );
        logic [DATA_W-1:0] result;
        result = old_word;
        for (int i = 0; i < BYTES; i++) begin
            if (sel[i]) begin
                result[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return result;
    endfunction

endpackage

//--- design/main_mem.sv
`timescale 1ns/1ps

module main_mem (
    input  logic              clk,
    input  logic              rst_n,
    input  mem_pkg::mem_req_t cache2mem_i,
    output mem_pkg::mem_rsp_t mem2cache_o
);
    import mem_pkg::*;

    logic [DATA_W-1:0]    mem_q [MEM_WORDS];
    mem_req_t             req_q;
    logic                 busy_q;
    logic                 ack_q;
    logic [LAT_W-1:0]     cnt_q;
    logic [DATA_W-1:0]    rdata_q;
    logic [MEM_IDX_W-1:0] word_idx;
    logic                 start;
    logic                 done;

    // Not accepting in the ack cycle, the requester still holds req there
    assign start    = !busy_q && !ack_q && cache2mem_i.req;
    assign done     = busy_q && (cnt_q == '0);
    assign word_idx = req_q.addr[OFFSET_W +: MEM_IDX_W];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            ack_q  <= 1'b0;
            cnt_q  <= '0;
        end else begin
            ack_q <= done;
            if (start) begin
                busy_q <= 1'b1;
                cnt_q  <= LAT_W'(MEM_LATENCY - 1);
            end else if (done) begin
                busy_q <= 1'b0;
            end else if (busy_q) begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    // Word array and read data
    always_ff @(posedge clk) begin
        if (start) begin
            req_q <= cache2mem_i;
        end
        if (done) begin
            if (req_q.w_en) begin
                mem_q[word_idx] <= merge_bytes(mem_q[word_idx], req_q.w_data,
                                               req_q.sel_byte);
            end
            rdata_q <= mem_q[word_idx];
        end
    end

    assign mem2cache_o.ack    = ack_q;
    assign mem2cache_o.r_data = rdata_q;

endmodule

//--- design/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
    input  logic              clk,
    input  logic              rst_n,

    // Data cache side
    input  mem_pkg::mem_req_t dcache2mem_i,
    input  logic              dcache_kill_i,
    output mem_pkg::mem_rsp_t mem2dcache_o,

    // Instruction cache side
    input  mem_pkg::mem_req_t icache2mem_i,
    input  logic              icache_kill_i,
    output mem_pkg::mem_rsp_t mem2icache_o,

    // Main memory side
    output mem_pkg::mem_req_t arb2mem_o,
    input  mem_pkg::mem_rsp_t mem2arb_i
);
    import mem_pkg::*;

    mem_arb_state_e state_q;
    mem_arb_state_e state_d;
    mem_req_t       req_q;
    mem_req_t       req_d;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= MEM_IDLE;
            req_q   <= '0;
        end else begin
            state_q <= state_d;
            req_q   <= req_d;
        end
    end

    always_comb begin
        state_d      = state_q;
        req_d        = req_q;
        mem2dcache_o = '0;
        mem2icache_o = '0;

        case (state_q)
            MEM_IDLE: begin
                // Data cache has fixed priority, a killed requester is not granted
                if (dcache2mem_i.req && !dcache_kill_i) begin
                    req_d   = dcache2mem_i;
                    state_d = MEM_DCACHE;
                end else if (icache2mem_i.req && !icache_kill_i) begin
                    req_d   = icache2mem_i;
                    state_d = MEM_ICACHE;
                end
            end

            MEM_DCACHE: begin
                if (mem2arb_i.ack) begin
                    req_d   = '0;
                    state_d = MEM_IDLE;
                    if (!dcache_kill_i) begin
                        mem2dcache_o = mem2arb_i;
                    end
                end else if (dcache_kill_i) begin
                    state_d = MEM_DKILL;
                end
            end

            MEM_ICACHE: begin
                if (mem2arb_i.ack) begin
                    req_d   = '0;
                    state_d = MEM_IDLE;
                    if (!icache_kill_i) begin
                        mem2icache_o = mem2arb_i;
                    end
                end else if (icache_kill_i) begin
                    state_d = MEM_IKILL;
                end
            end

            // Memory still owes an ack, drop it when it comes
            MEM_DKILL, MEM_IKILL: begin
                if (mem2arb_i.ack) begin
                    req_d   = '0;
                    state_d = MEM_IDLE;
                end
            end

            default: begin
                req_d   = '0;
                state_d = MEM_IDLE;
            end
        endcase
    end

    assign arb2mem_o = req_q;

endmodule

//--- design/dport_arbiter.sv
`timescale 1ns/1ps

module dport_arbiter (
    input  logic              clk,
    input  logic              rst_n,
    input  mem_pkg::lsu_req_t lsu_req_i,
    output mem_pkg::lsu_rsp_t lsu_rsp_o,
    input  mem_pkg::mmu_req_t mmu_req_i,
    output mem_pkg::mmu_rsp_t mmu_rsp_o,
    output mem_pkg::lsu_req_t dc_req_o,
    output logic              dc_kill_o,
    input  mem_pkg::lsu_rsp_t dc_rsp_i
);
    import mem_pkg::*;

    port_arb_state_e state_q;
    port_arb_state_e state_d;
    lsu_req_t        mmu_rd;

    // Page-table reads are always full words
    assign mmu_rd.req      = mmu_req_i.r_req;
    assign mmu_rd.addr     = mmu_req_i.paddr;
    assign mmu_rd.w_data   = '0;
    assign mmu_rd.sel_byte = '1;
    assign mmu_rd.w_en     = 1'b0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= PORT_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d   = state_q;
        dc_req_o  = '0;
        dc_kill_o = 1'b0;
        lsu_rsp_o = '0;
        mmu_rsp_o = '0;

        case (state_q)
            PORT_IDLE: begin
                if (lsu_req_i.req) begin
                    dc_req_o = lsu_req_i;
                    state_d  = PORT_LSU;
                end else if (mmu_req_i.r_req && !mmu_req_i.flush_req) begin
                    dc_req_o = mmu_rd;
                    state_d  = PORT_MMU;
                end
            end

            PORT_LSU: begin
                dc_req_o = lsu_req_i;
                if (dc_rsp_i.ack) begin
                    lsu_rsp_o = dc_rsp_i;
                    state_d   = PORT_IDLE;
                end
            end

            PORT_MMU: begin
                // A flush abandons the walk and wins over a same-cycle ack
                if (mmu_req_i.flush_req) begin
                    dc_kill_o = 1'b1;
                    state_d   = PORT_IDLE;
                end else begin
                    dc_req_o = mmu_rd;
                    if (dc_rsp_i.ack) begin
                        mmu_rsp_o.r_valid = 1'b1;
                        mmu_rsp_o.r_data  = dc_rsp_i.r_data;
                        state_d           = PORT_IDLE;
                    end
                end
            end

            default: state_d = PORT_IDLE;
        endcase
    end

endmodule

//--- design/icache.sv
`timescale 1ns/1ps

module icache (
    input  logic                clk,
    input  logic                rst_n,
    input  mem_pkg::fetch_req_t fetch_req_i,
    output mem_pkg::fetch_rsp_t fetch_rsp_o,
    output mem_pkg::mem_req_t   icache2mem_o,
    output logic                kill_o,
    input  mem_pkg::mem_rsp_t   mem2icache_i
);
    import mem_pkg::*;

    cache_state_e           state_q;
    logic [TAG_W-1:0]       tag_q  [CACHE_LINES];
    logic [DATA_W-1:0]      data_q [CACHE_LINES];
    logic [CACHE_LINES-1:0] valid_q;
    logic [ADDR_W-1:0]      addr_q;
    logic                   ack_q;
    logic [DATA_W-1:0]      rdata_q;
    logic [IDX_W-1:0]       in_idx;
    logic [IDX_W-1:0]       q_idx;
    logic                   in_hit;
    logic                   start;
    logic                   fill;

    assign in_idx = fetch_req_i.addr[OFFSET_W +: IDX_W];
    assign q_idx  = addr_q[OFFSET_W +: IDX_W];
    assign in_hit = valid_q[in_idx] &&
                    (tag_q[in_idx] == fetch_req_i.addr[ADDR_W-1 -: TAG_W]);

    assign start  = (state_q == CACHE_IDLE) && fetch_req_i.req && !fetch_req_i.kill &&
                    !ack_q;
    assign kill_o = (state_q == CACHE_MISS) && fetch_req_i.kill;
    assign fill   = (state_q == CACHE_MISS) && !fetch_req_i.kill && mem2icache_i.ack;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= CACHE_IDLE;
            valid_q <= '0;
            ack_q   <= 1'b0;
        end else begin
            ack_q <= (start && in_hit) || fill;
            if (start && !in_hit) begin
                state_q <= CACHE_MISS;
            end else if (kill_o || fill) begin
                state_q <= CACHE_IDLE;
            end
            if (fill) begin
                valid_q[q_idx] <= 1'b1;
            end
        end
    end

    // Line arrays and fetch data
    always_ff @(posedge clk) begin
        if (start) begin
            addr_q  <= fetch_req_i.addr;
            rdata_q <= data_q[in_idx];
        end
        if (fill) begin
            tag_q[q_idx]  <= addr_q[ADDR_W-1 -: TAG_W];
            data_q[q_idx] <= mem2icache_i.r_data;
            rdata_q       <= mem2icache_i.r_data;
        end
    end

    assign icache2mem_o.req      = (state_q == CACHE_MISS);
    assign icache2mem_o.addr     = addr_q;
    assign icache2mem_o.w_data   = '0;
    assign icache2mem_o.sel_byte = '1;
    assign icache2mem_o.w_en     = 1'b0;

    assign fetch_rsp_o.ack  = ack_q;
    assign fetch_rsp_o.data = rdata_q;

endmodule

//--- design/dcache.sv
`timescale 1ns/1ps

module dcache (
    input  logic              clk,
    input  logic              rst_n,
    input  mem_pkg::lsu_req_t dc_req_i,
    input  logic              dc_kill_i,
    output mem_pkg::lsu_rsp_t dc_rsp_o,
    output mem_pkg::mem_req_t dcache2mem_o,
    output logic              kill_o,
    input  mem_pkg::mem_rsp_t mem2dcache_i
);
    import mem_pkg::*;

    cache_state_e           state_q;
    lsu_req_t               req_q;
    logic [TAG_W-1:0]       tag_q  [CACHE_LINES];
    logic [DATA_W-1:0]      data_q [CACHE_LINES];
    logic [CACHE_LINES-1:0] valid_q;
    logic                   ack_q;
    logic                   kill_q;
    logic [DATA_W-1:0]      rdata_q;
    logic [IDX_W-1:0]       in_idx;
    logic [IDX_W-1:0]       q_idx;
    logic                   in_hit;
    logic                   q_hit;
    logic                   start;
    logic                   fill;
    logic                   wr_done;

    assign in_idx = dc_req_i.addr[OFFSET_W +: IDX_W];
    assign q_idx  = req_q.addr[OFFSET_W +: IDX_W];
    assign in_hit = valid_q[in_idx] && (tag_q[in_idx] == dc_req_i.addr[ADDR_W-1 -: TAG_W]);
    assign q_hit  = valid_q[q_idx] && (tag_q[q_idx] == req_q.addr[ADDR_W-1 -: TAG_W]);

    assign start   = (state_q == CACHE_IDLE) && dc_req_i.req && !ack_q;
    assign fill    = (state_q == CACHE_MISS) && !dc_kill_i && mem2dcache_i.ack;
    assign wr_done = (state_q == CACHE_WRITE) && mem2dcache_i.ack;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= CACHE_IDLE;
            valid_q <= '0;
            ack_q   <= 1'b0;
            kill_q  <= 1'b0;
        end else begin
            ack_q  <= (start && !dc_req_i.w_en && in_hit) || fill || wr_done;
            // Kept one cycle past the dropped request, so a fresh grant still sees it
            kill_q <= (state_q == CACHE_MISS) && dc_kill_i;
            case (state_q)
                CACHE_IDLE: begin
                    if (start && dc_req_i.w_en) begin
                        state_q <= CACHE_WRITE;
                    end else if (start && !in_hit) begin
                        state_q <= CACHE_MISS;
                    end
                end
                CACHE_MISS: begin
                    if (dc_kill_i || fill) begin
                        state_q <= CACHE_IDLE;
                    end
                end
                CACHE_WRITE: begin
                    if (wr_done) begin
                        state_q <= CACHE_IDLE;
                    end
                end
                default: state_q <= CACHE_IDLE;
            endcase
            if (fill) begin
                valid_q[q_idx] <= 1'b1;
            end
        end
    end

    // Line arrays, request copy and load data
    always_ff @(posedge clk) begin
        if (start) begin
            req_q   <= dc_req_i;
            rdata_q <= data_q[in_idx];
        end
        if (fill) begin
            tag_q[q_idx]  <= req_q.addr[ADDR_W-1 -: TAG_W];
            data_q[q_idx] <= mem2dcache_i.r_data;
            rdata_q       <= mem2dcache_i.r_data;
        end
        // Write hits keep the line equal to memory, misses leave it alone
        if (wr_done && q_hit) begin
            data_q[q_idx] <= merge_bytes(data_q[q_idx], req_q.w_data, req_q.sel_byte);
        end
    end

    assign dcache2mem_o.req      = (state_q != CACHE_IDLE);
    assign dcache2mem_o.addr     = req_q.addr;
    assign dcache2mem_o.w_data   = req_q.w_data;
    assign dcache2mem_o.sel_byte = (state_q == CACHE_WRITE) ? req_q.sel_byte : '1;
    assign dcache2mem_o.w_en     = (state_q == CACHE_WRITE);

    assign kill_o          = kill_q;
    assign dc_rsp_o.ack    = ack_q;
    assign dc_rsp_o.r_data = rdata_q;

endmodule

//--- design/mem_top.sv
`timescale 1ns/1ps

module mem_top (
    input  logic                clk,
    input  logic                rst_n,

    // Instruction fetch
    input  mem_pkg::fetch_req_t fetch_req_i,
    output mem_pkg::fetch_rsp_t icache2if_o,

    // Load/store unit
    input  mem_pkg::lsu_req_t   lsu2dmem_i,
    output mem_pkg::lsu_rsp_t   dmem2lsu_o,

    // Page-table walker
    input  mem_pkg::mmu_req_t   mmu2dmem_i,
    output mem_pkg::mmu_rsp_t   dmem2mmu_o
);
    import mem_pkg::*;

    lsu_req_t dc_req;
    lsu_rsp_t dc_rsp;
    logic     dc_kill;
    mem_req_t dcache2mem;
    mem_rsp_t mem2dcache;
    logic     dcache_kill;
    mem_req_t icache2mem;
    mem_rsp_t mem2icache;
    logic     icache_kill;
    mem_req_t arb2mem;
    mem_rsp_t mem2arb;

    icache u_icache (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch_req_i  (fetch_req_i),
        .fetch_rsp_o  (icache2if_o),
        .icache2mem_o (icache2mem),
        .kill_o       (icache_kill),
        .mem2icache_i (mem2icache)
    );

    dport_arbiter u_dport_arbiter (
        .clk       (clk),
        .rst_n     (rst_n),
        .lsu_req_i (lsu2dmem_i),
        .lsu_rsp_o (dmem2lsu_o),
        .mmu_req_i (mmu2dmem_i),
        .mmu_rsp_o (dmem2mmu_o),
        .dc_req_o  (dc_req),
        .dc_kill_o (dc_kill),
        .dc_rsp_i  (dc_rsp)
    );

    dcache u_dcache (
        .clk          (clk),
        .rst_n        (rst_n),
        .dc_req_i     (dc_req),
        .dc_kill_i    (dc_kill),
        .dc_rsp_o     (dc_rsp),
        .dcache2mem_o (dcache2mem),
        .kill_o       (dcache_kill),
        .mem2dcache_i (mem2dcache)
    );

    mem_arbiter u_mem_arbiter (
        .clk           (clk),
        .rst_n         (rst_n),
        .dcache2mem_i  (dcache2mem),
        .dcache_kill_i (dcache_kill),
        .mem2dcache_o  (mem2dcache),
        .icache2mem_i  (icache2mem),
        .icache_kill_i (icache_kill),
        .mem2icache_o  (mem2icache),
        .arb2mem_o     (arb2mem),
        .mem2arb_i     (mem2arb)
    );

    main_mem u_main_mem (
        .clk         (clk),
        .rst_n       (rst_n),
        .cache2mem_i (arb2mem),
        .mem2cache_o (mem2arb)
    );

endmodule

//--- sim/clk_gen.sv
`timescale 1ns/1ps

module clk_gen (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    // 2 ns high, 2 ns low
    always begin
        #2 clk_o = ~clk_o;
    end

endmodule

//--- sim/mem_top_chk.sv
`timescale 1ns/1ps

module mem_top_chk (
    input logic                clk_i,
    input logic                rst_n_i,
    input mem_pkg::fetch_req_t fetch_req_i,
    input mem_pkg::fetch_rsp_t fetch_rsp_i,
    input mem_pkg::lsu_req_t   lsu_req_i,
    input mem_pkg::lsu_rsp_t   lsu_rsp_i,
    input mem_pkg::mmu_req_t   mmu_req_i,
    input mem_pkg::mmu_rsp_t   mmu_rsp_i,
    input mem_pkg::mem_req_t   mem_req_i,
    input mem_pkg::mem_rsp_t   mem_rsp_i
);

    property single_pulse(logic sig);
        @(posedge clk_i) disable iff (!rst_n_i) sig |=> !sig;
    endproperty

    property ack_needs_req(logic ack, logic req);
        @(posedge clk_i) disable iff (!rst_n_i) ack |-> $past(req);
    endproperty

    a_fetch_pulse: assert property (single_pulse(fetch_rsp_i.ack))
        else $error("fetch ack longer than one cycle");
    a_lsu_pulse: assert property (single_pulse(lsu_rsp_i.ack))
        else $error("LSU ack longer than one cycle");
    a_mmu_pulse: assert property (single_pulse(mmu_rsp_i.r_valid))
        else $error("MMU r_valid longer than one cycle");

    // The requester drops req in the ack cycle, so look one cycle back
    a_fetch_req: assert property (ack_needs_req(fetch_rsp_i.ack, fetch_req_i.req))
        else $error("fetch ack without a fetch request");
    a_lsu_req: assert property (ack_needs_req(lsu_rsp_i.ack, lsu_req_i.req))
        else $error("LSU ack without an LSU request");
    a_mmu_req: assert property (ack_needs_req(mmu_rsp_i.r_valid, mmu_req_i.r_req))
        else $error("MMU r_valid without an MMU request");

    // A granted memory request stays put until memory acks it
    a_one_grant: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_req_i.req && !mem_rsp_i.ack |=> mem_req_i.req && $stable(mem_req_i))
        else $error("memory arbiter changed its grant before the memory ack");

endmodule

//--- sim/mem_top_tb.sv
`timescale 1ns/1ps

module mem_top_tb;
    import mem_pkg::*;

    localparam int TIMEOUT    = 200;
    localparam int KILL_DELAY = 3;
    localparam int RESET_CYC  = 3;

    logic       clk;
    logic       rst_n;
    fetch_req_t fetch_req;
    fetch_rsp_t fetch_rsp;
    lsu_req_t   lsu_req;
    lsu_rsp_t   lsu_rsp;
    mmu_req_t   mmu_req;
    mmu_rsp_t   mmu_rsp;

    // Last word stored at each memory index, gives the MMU word of an LM case
    logic [DATA_W-1:0] written [MEM_WORDS];

    // Lines the instruction cache should hold after each completed fetch
    logic [TAG_W-1:0]       itag [CACHE_LINES];
    logic [CACHE_LINES-1:0] ivalid;

    int                errors;
    int                cases_run;
    int                cases_bad;
    bit                aborted;
    bit                f_seen;
    bit                l_seen;
    bit                m_seen;
    int                f_cycle;
    int                l_cycle;
    int                m_cycle;
    logic [DATA_W-1:0] f_data;
    logic [DATA_W-1:0] l_data;
    logic [DATA_W-1:0] m_data;

    clk_gen u_clk_gen (
        .clk_o (clk)
    );

    mem_top u_mem_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_req_i (fetch_req),
        .icache2if_o (fetch_rsp),
        .lsu2dmem_i  (lsu_req),
        .dmem2lsu_o  (lsu_rsp),
        .mmu2dmem_i  (mmu_req),
        .dmem2mmu_o  (mmu_rsp)
    );

    bind mem_top mem_top_chk u_mem_top_chk (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .fetch_req_i (fetch_req_i),
        .fetch_rsp_i (icache2if_o),
        .lsu_req_i   (lsu2dmem_i),
        .lsu_rsp_i   (dmem2lsu_o),
        .mmu_req_i   (mmu2dmem_i),
        .mmu_rsp_i   (dmem2mmu_o),
        .mem_req_i   (arb2mem),
        .mem_rsp_i   (mem2arb)
    );

    task automatic report_problem(input string msg);
        $display("ERROR at time %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic check_value(input string name, input logic [DATA_W-1:0] got,
                               input logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("FAIL time %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic drive_lsu(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                             input logic [BYTES-1:0] sel, input logic w_en);
        lsu_req.req      = 1'b1;
        lsu_req.addr     = addr;
        lsu_req.w_data   = data;
        lsu_req.sel_byte = sel;
        lsu_req.w_en     = w_en;
    endtask

    task automatic drive_mmu(input logic [ADDR_W-1:0] addr);
        mmu_req.r_req     = 1'b1;
        mmu_req.paddr     = addr;
        mmu_req.flush_req = 1'b0;
    endtask

    task automatic drive_fetch(input logic [ADDR_W-1:0] addr);
        fetch_req.req  = 1'b1;
        fetch_req.addr = addr;
        fetch_req.kill = 1'b0;
    endtask

    // Lets a miss get to memory before it is killed
    task automatic wait_into_miss();
        repeat (KILL_DELAY) begin
            @(negedge clk);
            if (fetch_rsp.ack || lsu_rsp.ack || mmu_rsp.r_valid) begin
                report_problem("a response arrived before the kill was raised");
            end
        end
    endtask

    // Waits for the expected responses; with none expected, watches a full window
    task automatic await_acks(input bit exp_f, input bit exp_l, input bit exp_m);
        int cycles;
        cycles = 0;
        f_seen = 1'b0;
        l_seen = 1'b0;
        m_seen = 1'b0;
        while (cycles < TIMEOUT && !((exp_f || exp_l || exp_m) && f_seen == exp_f &&
               l_seen == exp_l && m_seen == exp_m)) begin
            @(negedge clk);
            cycles++;
            if (fetch_rsp.ack) begin
                if (exp_f && !f_seen) begin
                    f_seen    = 1'b1;
                    f_data    = fetch_rsp.data;
                    f_cycle   = cycles;
                    fetch_req = '0;
                end else begin
                    report_problem("fetch ack without a pending fetch");
                end
            end
            if (lsu_rsp.ack) begin
                if (exp_l && !l_seen) begin
                    l_seen  = 1'b1;
                    l_data  = lsu_rsp.r_data;
                    l_cycle = cycles;
                    lsu_req = '0;
                end else begin
                    report_problem("LSU ack without a pending LSU request");
                end
            end
            if (mmu_rsp.r_valid) begin
                if (exp_m && !m_seen) begin
                    m_seen  = 1'b1;
                    m_data  = mmu_rsp.r_data;
                    m_cycle = cycles;
                    mmu_req = '0;
                end else begin
                    report_problem("MMU r_valid without a pending MMU read");
                end
            end
        end
        if ((exp_f && !f_seen) || (exp_l && !l_seen) || (exp_m && !m_seen)) begin
            report_problem($sformatf("no response within %0d cycles", TIMEOUT));
            aborted = 1'b1;
        end
    endtask

    task automatic run_case(input logic [15:0] op, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] data, input logic [BYTES-1:0] sel,
                            input logic [DATA_W-1:0] exp);
        logic [MEM_IDX_W-1:0] idx;
        logic [MEM_IDX_W-1:0] mmu_idx;
        logic [IDX_W-1:0]     iidx;
        logic                 line_hit;
        idx     = addr[OFFSET_W +: MEM_IDX_W];
        mmu_idx = data[OFFSET_W +: MEM_IDX_W];
        iidx    = addr[OFFSET_W +: IDX_W];
        case (op)
            "SW": begin
                drive_lsu(addr, data, sel, 1'b1);
                await_acks(1'b0, 1'b1, 1'b0);
                written[idx] = exp;
            end
            "LW": begin
                drive_lsu(addr, '0, '1, 1'b0);
                await_acks(1'b0, 1'b1, 1'b0);
                check_value("dmem2lsu_o.r_data", l_data, exp);
            end
            "MR": begin
                drive_mmu(addr);
                await_acks(1'b0, 1'b0, 1'b1);
                check_value("dmem2mmu_o.r_data", m_data, exp);
            end
            "MF": begin
                drive_mmu(addr);
                wait_into_miss();
                mmu_req.flush_req = 1'b1;
                @(negedge clk);
                if (mmu_rsp.r_valid) begin
                    report_problem("flushed MMU read still raised r_valid");
                end
                mmu_req = '0;
                await_acks(1'b0, 1'b0, 1'b0);
            end
            "IF": begin
                line_hit = ivalid[iidx] && (itag[iidx] == addr[ADDR_W-1 -: TAG_W]);
                drive_fetch(addr);
                await_acks(1'b1, 1'b0, 1'b0);
                check_value("icache2if_o.data", f_data, exp);
                // A hit answers in the cycle after the request is sampled
                if (line_hit) begin
                    check_value("fetch_hit_latency", f_cycle, 1);
                end
                ivalid[iidx] = 1'b1;
                itag[iidx]   = addr[ADDR_W-1 -: TAG_W];
            end
            "IK": begin
                drive_fetch(addr);
                wait_into_miss();
                fetch_req.kill = 1'b1;
                @(negedge clk);
                if (fetch_rsp.ack) begin
                    report_problem("killed fetch still acked");
                end
                fetch_req = '0;
                await_acks(1'b0, 1'b0, 1'b0);
            end
            "LM": begin
                // Both requests raised in the same cycle
                drive_lsu(addr, '0, '1, 1'b0);
                drive_mmu(data);
                await_acks(1'b0, 1'b1, 1'b1);
                check_value("dmem2lsu_o.r_data", l_data, exp);
                check_value("dmem2mmu_o.r_data", m_data, written[mmu_idx]);
                check_value("lsu_ack_before_r_valid", DATA_W'(l_cycle < m_cycle), 1);
            end
            default: begin
                report_problem($sformatf("unknown operation %s in the cases file", op));
            end
        endcase
    endtask

    initial begin
        string             line;
        int                fd;
        int                n;
        int                gap;
        int                errs_before;
        logic [15:0]       op;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [BYTES-1:0]  sel;
        logic [DATA_W-1:0] exp;

        fetch_req = '0;
        lsu_req   = '0;
        mmu_req   = '0;
        rst_n     = 1'b0;
        ivalid    = '0;
        errors    = 0;
        cases_run = 0;
        cases_bad = 0;
        aborted   = 1'b0;
        gap       = $urandom(32'h9f4b_7160);

        repeat (RESET_CYC) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        fd = $fopen("sim/mem_cases.txt", "r");
        if (fd == 0) begin
            report_problem("could not open sim/mem_cases.txt");
            aborted = 1'b1;
        end
        while (fd != 0 && !aborted && !$feof(fd)) begin
            line = "";
            n    = $fgets(line, fd);
            if (n > 1 && line[0] != "#") begin
                n = $sscanf(line, "%s %h %h %h %h", op, addr, data, sel, exp);
                if (n != 5) begin
                    report_problem({"malformed line in the cases file: ", line});
                end else begin
                    errs_before = errors;
                    run_case(op, addr, data, sel, exp);
                    cases_run++;
                    if (errors == errs_before) begin
                        $display("case %0d %s %h: ok", cases_run, op, addr);
                    end else begin
                        cases_bad++;
                        $display("case %0d %s %h: mismatch", cases_run, op, addr);
                    end
                    // Random idle gap, at least the cycle after the ack
                    gap = 1 + $urandom % 4;
                    repeat (gap) @(negedge clk);
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        $display("cases %0d, passed %0d, failed %0d, errors %0d",
                 cases_run, cases_run - cases_bad, cases_bad, errors);
        if (errors == 0 && cases_run > 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- sim/mem_cases.txt
# op addr     data     sel expected   (all hex)
# SW: expected is the memory word after the store. IK, MF: expected unused.
# LM: data is the MMU address, expected is the LSU word.
SW 00000010 11223344 f 11223344
LW 00000010 00000000 f 11223344
SW 00000010 aabbccdd 5 11bb33dd
LW 00000010 00000000 f 11bb33dd
SW 00000050 cafef00d f cafef00d
SW 00000050 00000099 1 cafef099
LW 00000050 00000000 f cafef099
SW 00000090 5a5a0001 f 5a5a0001
MR 00000090 00000000 f 5a5a0001
SW 00000024 0badc0de f 0badc0de
SW 00000104 12345678 f 12345678
LM 00000024 00000104 f 0badc0de
SW 00000200 00000013 f 00000013
IF 00000200 00000000 f 00000013
IF 00000200 00000000 f 00000013
SW 00000208 00a00093 f 00a00093
IK 00000208 00000000 f 00000000
IF 00000208 00000000 f 00a00093
SW 000000c8 deadbeef f deadbeef
MF 000000c8 00000000 f 00000000
MR 000000c8 00000000 f deadbeef
LW 00000090 00000000 f 5a5a0001

//--- build.f
design/mem_pkg.sv
design/main_mem.sv
design/mem_arbiter.sv
design/dport_arbiter.sv
design/icache.sv
design/dcache.sv
design/mem_top.sv
sim/clk_gen.sv
sim/mem_top_chk.sv
sim/mem_top_tb.sv
